/* eeprom_rw.f */
verilog/eeprom_pkg.sv
verilog/bus_condition.sv
verilog/byte_shifter.sv
verilog/eeprom_ctrl.sv
verilog/eeprom_rw.sv
sim/eeprom_model.sv
sim/eeprom_checker.sv
sim/tb_eeprom.sv

/* run_sim.sh */
#!/bin/bash
# build and run the eeprom_rw testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_eeprom \
    -f eeprom_rw.f -o tb_eeprom > build.log 2>&1 \
    && ./obj_dir/tb_eeprom > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
! grep -q "sim failed" sim.log || exit 1
exit 0

/* sim/eeprom_checker.sv */
`timescale 1ns/1ns
module eeprom_checker import eeprom_pkg::*; #(
    parameter logic [3:0] dev_code = dev_code_std
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    input  logic [data_w-1:0] rdata,
    input  logic              ack,
    input  logic              nack,
    input  logic              scl,
    input  logic              sda_oe,
    input  logic              sda_in,
    input  logic              force_nack,
    input  logic [data_w-1:0] exp_data,
    output int                pass_cnt,
    output int                fail_cnt,
    output int                err_cnt
);

    logic [data_w-1:0] ref_mem [0:(1<<addr_w)-1];
    logic              ref_valid [0:(1<<addr_w)-1];
    ser_byte_u         ctrl_log [0:3];
    ser_byte_u         cap;
    ser_byte_u         cb;
    int                starts = 0;
    int                stops = 0;
    int                bits = 0;
    logic              capture = 1'b0;
    logic              scl_q = 1'b0;
    logic              sda_q = 1'b1;
    logic              busy;
    logic              reset_q;
    logic              op_rd;
    logic              op_force;
    logic [addr_w-1:0] op_addr;
    logic [data_w-1:0] op_data;
    logic [data_w-1:0] op_exp;
    int                op_starts;
    int                op_stops;
    int                op_errs;
    int                idle_starts;
    int                test_no;

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, got);
        err_cnt = err_cnt + 1;
    endtask

    task automatic report_problem(input string what);
        $display("error: %s", what);
        err_cnt = err_cnt + 1;
    endtask

    // bus monitor, grabs the byte after each start
    always @(posedge scl or negedge scl or posedge sda_in or negedge sda_in) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda_in === 1'b0) begin
            starts  = starts + 1;
            bits    = 0;
            capture = 1'b1;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda_in === 1'b1) begin
            stops = stops + 1;
        end else if (scl === 1'b1 && scl_q === 1'b0 && capture) begin
            cap.raw = {cap.raw[6:0], sda_in};
            bits    = bits + 1;
            if (bits == 8) begin
                ctrl_log[starts[1:0]] = cap;
                capture               = 1'b0;
            end
        end
        scl_q = scl;
        sda_q = sda_in;
    end

    always @(posedge CLK) begin
        if (RESET) begin
            busy        = 1'b0;
            reset_q     = 1'b1;
            pass_cnt    = 0;
            fail_cnt    = 0;
            err_cnt     = 0;
            test_no     = 0;
            idle_starts = starts;
            for (int i = 0; i < (1 << addr_w); i++)
                ref_valid[i] = 1'b0;
        end else begin
            if (reset_q) begin
                reset_q = 1'b0;
                if (ack !== 1'b0) report_mismatch("ack", 16'h0, 16'(ack));
                if (nack !== 1'b0) report_mismatch("nack", 16'h0, 16'(nack));
                if (sda_oe !== 1'b0) report_mismatch("sda_oe", 16'h0, 16'(sda_oe));
            end
            if (ack) begin
                if (!busy) begin
                    report_problem("ack pulse with no operation in progress");
                end else begin
                    busy    = 1'b0;
                    test_no = test_no + 1;
                    if (starts - op_starts != (op_rd ? 2 : 1))
                        report_problem($sformatf("saw %0d start conditions in one operation",
                                                 starts - op_starts));
                    for (int k = 0; k < 2; k++) begin
                        if (k < starts - op_starts) begin
                            cb = ctrl_log[2'(op_starts + k + 1)];
                            if (cb.ctrl.dev != dev_code)
                                report_mismatch("ctrl_byte.dev", 16'(dev_code), 16'(cb.ctrl.dev));
                            if (cb.ctrl.blk != op_addr[10:8])
                                report_mismatch("ctrl_byte.blk", 16'(op_addr[10:8]),
                                                16'(cb.ctrl.blk));
                            if (cb.ctrl.rd_flag != (k == 1))
                                report_mismatch("ctrl_byte.rd_flag", 16'(k == 1),
                                                16'(cb.ctrl.rd_flag));
                        end
                    end
                    if (stops == op_stops)
                        report_problem("no stop condition before ack");
                    if (nack != op_force)
                        report_mismatch("nack", 16'(op_force), 16'(nack));
                    if (op_rd && !op_force) begin
                        if (!ref_valid[op_addr]) begin
                            report_problem("read of an address that was never written");
                        end else begin
                            if (ref_mem[op_addr] != op_exp)
                                report_problem("input file and reference memory disagree");
                            if (rdata != ref_mem[op_addr])
                                report_mismatch("rdata", 16'(ref_mem[op_addr]), 16'(rdata));
                        end
                    end else if (!op_rd && !op_force) begin
                        ref_mem[op_addr]   = op_data;
                        ref_valid[op_addr] = 1'b1;
                    end
                    if (err_cnt == op_errs)
                        pass_cnt = pass_cnt + 1;
                    else
                        fail_cnt = fail_cnt + 1;
                    $display("test %0d: %s 0x%03h%s %s", test_no, op_rd ? "read" : "write",
                             op_addr, op_force ? " nack forced" : "",
                             (err_cnt == op_errs) ? "ok" : "FAILED");
                    idle_starts = starts;
                end
            end else if (!busy && (wr || rd)) begin
                if (starts != idle_starts)
                    report_problem("start condition on the bus with no request pending");
                busy      = 1'b1;
                op_rd     = !wr;   // write wins
                op_force  = force_nack;
                op_addr   = addr;
                op_data   = wdata;
                op_exp    = exp_data;
                op_starts = starts;
                op_stops  = stops;
                op_errs   = err_cnt;
            end
        end
    end

endmodule

/* sim/eeprom_input.txt */
# op addr(hex) data(hex) force_nack expected_rdata(hex)
# op: W write, R read, B wr and rd together, D write plus rd strobe while busy
W 0a5 3c 0 00
R 0a5 00 0 3c
W 7f0 c3 0 00
R 7f0 00 0 c3
W 312 5a 1 00
R 312 00 1 00
B 312 81 0 00
R 312 00 0 81
D 455 99 0 00
R 455 00 0 99

/* sim/eeprom_model.sv */
`timescale 1ns/1ns
module eeprom_model import eeprom_pkg::*; #(
    parameter logic [3:0] dev_code = dev_code_std
) (
    input  logic scl,
    input  logic sda_in,
    input  logic force_nack,
    output logic sda_drive
);

    logic [data_w-1:0] mem [0:(1<<addr_w)-1];
    ser_byte_u         sh;
    logic [data_w-1:0] tx_sh;
    logic [3:0]        cnt;
    logic [1:0]        byte_idx;
    logic [2:0]        blk;
    logic [7:0]        word;
    logic              busy = 1'b0;
    logic              in_ack = 1'b0;
    logic              tx_mode = 1'b0;
    logic              rd_req = 1'b0;
    logic              ok;
    logic              scl_q = 1'b0;
    logic              sda_q = 1'b1;

    initial begin
        sda_drive = 1'b1;
        void'($urandom(35203));
        for (int i = 0; i < (1 << addr_w); i++)
            mem[i] = 8'($urandom) ^ 8'(i) ^ 8'(i >> 8);
    end

    always @(posedge scl or negedge scl or posedge sda_in or negedge sda_in) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q !== sda_in) begin
            if (sda_in === 1'b0) begin  // start or repeated start
                busy     = 1'b1;
                cnt      = 4'd0;
                in_ack   = 1'b0;
                tx_mode  = 1'b0;
                rd_req   = 1'b0;
                byte_idx = 2'd0;
            end else begin
                busy = 1'b0;            // stop
            end
            sda_drive = 1'b1;
        end else if (scl === 1'b1 && scl_q === 1'b0) begin
            if (busy && !in_ack && cnt < 4'd8) begin
                sh.raw = {sh.raw[6:0], sda_in};
                cnt    = cnt + 4'd1;
            end
        end else if (scl === 1'b0 && scl_q === 1'b1 && busy) begin
            if (!in_ack && cnt == 4'd8) begin
                in_ack = 1'b1;
                if (tx_mode) begin
                    sda_drive = 1'b1;   // master answers
                end else begin
                    ok = !force_nack;
                    if (byte_idx == 2'd0)
                        ok = ok && (sh.ctrl.dev == dev_code);
                    if (ok) begin
                        case (byte_idx)
                            2'd0: begin
                                blk    = sh.ctrl.blk;
                                rd_req = sh.ctrl.rd_flag;
                            end
                            2'd1:    word = sh.raw;
                            default: mem[{blk, word}] = sh.raw;
                        endcase
                        byte_idx  = byte_idx + 2'd1;
                        sda_drive = 1'b0;
                    end else begin
                        busy = 1'b0;    // stay off the bus until next start
                    end
                end
            end else if (in_ack) begin
                in_ack    = 1'b0;
                cnt       = 4'd0;
                sda_drive = 1'b1;
                if (tx_mode) begin
                    tx_mode = 1'b0;     // single byte read only
                    busy    = 1'b0;
                end else if (rd_req) begin
                    rd_req    = 1'b0;
                    tx_mode   = 1'b1;
                    tx_sh     = mem[{blk, word}];
                    sda_drive = tx_sh[7];
                end
            end else if (tx_mode) begin
                tx_sh     = {tx_sh[6:0], 1'b0};
                sda_drive = tx_sh[7];
            end
        end
        scl_q = scl;
        sda_q = sda_in;
    end

endmodule

/* sim/tb_eeprom.sv */
`timescale 1ns/1ns
module tb_eeprom import eeprom_pkg::*; ();

    logic              CLK = 1'b0;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] rdata;
    logic              ack;
    logic              nack;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    logic              sda_in;
    logic              model_sda;
    logic              force_nack;
    logic [data_w-1:0] exp_data;
    int                pass_cnt;
    int                fail_cnt;
    int                err_cnt;

    logic [7:0]        t_op [0:63];
    logic [addr_w-1:0] t_addr [0:63];
    logic [data_w-1:0] t_data [0:63];
    logic              t_force [0:63];
    logic [data_w-1:0] t_exp [0:63];
    int                n_tests = 0;
    int                limit = 0;
    int                cycles = 0;
    int                fd;

    always #10 CLK = ~CLK;

    assign sda_in = (sda_oe ? sda_out : 1'b1) & model_sda; // wired-AND

    eeprom_rw #(.dev_code(dev_code_std)) i_dut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .nack(nack), .scl(scl), .sda_out(sda_out),
        .sda_oe(sda_oe), .sda_in(sda_in)
    );

    eeprom_model #(.dev_code(dev_code_std)) i_model (
        .scl(scl), .sda_in(sda_in), .force_nack(force_nack), .sda_drive(model_sda)
    );

    eeprom_checker #(.dev_code(dev_code_std)) i_checker (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .nack(nack), .scl(scl), .sda_oe(sda_oe),
        .sda_in(sda_in), .force_nack(force_nack), .exp_data(exp_data),
        .pass_cnt(pass_cnt), .fail_cnt(fail_cnt), .err_cnt(err_cnt)
    );

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, an operation never finished", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic load_tests();
        string             line;
        string             op_s;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] d;
        logic [data_w-1:0] e;
        int                f;
        int                n;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %d %h", op_s, a, d, f, e);
                if (n == 5 && n_tests < 64) begin
                    t_op[n_tests]    = op_s[0];
                    t_addr[n_tests]  = a;
                    t_data[n_tests]  = d;
                    t_force[n_tests] = (f != 0);
                    t_exp[n_tests]   = e;
                    n_tests = n_tests + 1;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int i);
        @(posedge CLK);
        #2;
        addr       = t_addr[i];
        wdata      = t_data[i];
        force_nack = t_force[i];
        exp_data   = t_exp[i];
        wr         = (t_op[i] != "R");
        rd         = (t_op[i] == "R") || (t_op[i] == "B");
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
        if (t_op[i] == "D") begin
            repeat (20) @(posedge CLK); // well inside the write
            #2;
            rd = 1'b1;
            @(posedge CLK);
            #2;
            rd = 1'b0;
        end
        while (ack !== 1'b1) begin
            @(posedge CLK);
            #1;
        end
        if (t_op[i] == "D")
            repeat (120) @(posedge CLK); // room for a whole read, no second ack may show
        else
            repeat (3) @(posedge CLK);
    endtask

    initial begin
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        force_nack = 1'b0;
        exp_data   = '0;
        fd = $fopen("sim/eeprom_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/eeprom_input.txt");
            $display("sim failed");
            $finish;
        end else begin
            load_tests();
            limit = n_tests * 200 + 100;
            repeat (5) @(posedge CLK);
            #2;
            RESET = 1'b0;
            repeat (10) @(posedge CLK); // idle bus, no start expected
            for (int i = 0; i < n_tests; i++)
                run_test(i);
            repeat (5) @(posedge CLK);
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     n_tests, pass_cnt, fail_cnt, err_cnt);
            if (err_cnt == 0 && pass_cnt == n_tests && n_tests > 0)
                $display("sim passed");
            else
                $display("sim failed");
            $finish;
        end
    end

endmodule

/* verilog/bus_condition.sv */
`timescale 1ns/1ns
module bus_condition import eeprom_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cond_req,
    input  cond_kind_t cond_kind,
    input  logic       tx_bit,
    input  logic       tx_active,
    input  logic       bus_own,
    output logic       scl,
    output logic       bit_tick,
    output logic       cond_done,
    output logic       sda_out,
    output logic       sda_oe
);

    cond_kind_t kind;
    logic       active;
    logic [1:0] step;
    logic       cond_sda;

    // scl moves on the falling edge so sda updates land mid phase
    always_ff @(negedge CLK) begin
        if (RESET)
            scl <= 1'b0;
        else
            scl <= ~scl;
    end

    assign bit_tick = ~scl;

    // condition spans two scl periods, sda flips mid high of the second
    always_ff @(posedge CLK) begin
        if (RESET) begin
            active    <= 1'b0;
            step      <= 2'd0;
            kind      <= cond_start;
            cond_sda  <= 1'b1;
            cond_done <= 1'b0;
        end else begin
            cond_done <= 1'b0;
            if (cond_req) begin
                active   <= 1'b1;
                step     <= 2'd0;
                kind     <= cond_kind;
                cond_sda <= (cond_kind == cond_start); // setup level
            end else if (active) begin
                step <= step + 2'd1;
                if (step == 2'd2) begin
                    cond_sda  <= (kind == cond_stop);
                    cond_done <= 1'b1;
                end
                if (step == 2'd3)
                    active <= 1'b0;
            end
        end
    end

    assign sda_oe  = active | (bus_own & tx_active);
    assign sda_out = active ? cond_sda : tx_bit;

endmodule

/* verilog/byte_shifter.sv */
`timescale 1ns/1ns
module byte_shifter import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              bit_tick,
    input  logic              load,
    input  ser_byte_u         load_byte,
    input  logic              dir,
    input  logic              master_ack_bit,
    input  logic              sda_in,
    output logic              tx_bit,
    output logic              tx_active,
    output logic              byte_done,
    output logic              slave_ack,
    output logic [data_w-1:0] rx_byte
);

    logic [data_w-1:0] sh;
    logic [3:0]        cnt;     // 0 idle, 1..8 data slots, 9 acknowledge slot
    logic              rx_mode;
    logic              tx_shift;
    logic              rx_sample;

    assign tx_shift  = !rx_mode && cnt >= 4'd1 && cnt <= 4'd7;
    assign rx_sample = rx_mode && cnt >= 4'd1 && cnt <= 4'd8;
    assign rx_byte   = sh;

    // bit_tick edges fall mid scl low, the others mid scl high
    always_ff @(posedge CLK) begin
        if (RESET) begin
            cnt       <= 4'd0;
            rx_mode   <= 1'b0;
            tx_active <= 1'b0;
            tx_bit    <= 1'b1;
            byte_done <= 1'b0;
            slave_ack <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (bit_tick) begin
                if (load) begin
                    cnt       <= 4'd1;
                    rx_mode   <= dir;
                    tx_active <= (dir == dir_tx);
                    tx_bit    <= load_byte.raw[data_w-1];
                end else if (cnt >= 4'd1 && cnt <= 4'd7) begin
                    cnt <= cnt + 4'd1;
                    if (!rx_mode)
                        tx_bit <= sh[data_w-1];
                end else if (cnt == 4'd8) begin
                    cnt       <= 4'd9;
                    tx_active <= rx_mode;   // we only drive the ack slot when reading
                    tx_bit    <= master_ack_bit;
                end else if (cnt == 4'd9) begin
                    cnt       <= 4'd0;
                    tx_active <= 1'b0;
                end
            end else if (cnt == 4'd9) begin
                slave_ack <= sda_in;
                byte_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (bit_tick) begin
            if (load)
                sh <= {load_byte.raw[data_w-2:0], 1'b0}; // msb already on the wire
            else if (tx_shift)
                sh <= {sh[data_w-2:0], 1'b0};
        end else if (rx_sample) begin
            sh <= {sh[data_w-2:0], sda_in};
        end
    end

endmodule

/* verilog/eeprom_ctrl.sv */
`timescale 1ns/1ns
module eeprom_ctrl import eeprom_pkg::*; #(
    parameter logic [3:0] dev_code = dev_code_std
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    input  logic              bit_tick,
    input  logic              cond_done,
    input  logic              byte_done,
    input  logic              slave_ack,
    input  logic [data_w-1:0] rx_byte,
    output logic              cond_req,
    output cond_kind_t        cond_kind,
    output logic              load,
    output ser_byte_u         load_byte,
    output logic              dir,
    output logic              master_ack_bit,
    output logic              bus_own,
    output logic              ack,
    output logic              nack,
    output logic [data_w-1:0] rdata
);

    ctrl_state_t state;
    ctrl_state_t nxt;
    ctrl_state_t launch_st;  // phase whose command goes out this cycle
    logic        op_rd;      // 1 = random read
    logic        pending;    // start condition waits for the next bit tick
    logic        phase_end;
    logic        launch;

    // only one of the two blocks is ever busy
    assign phase_end = cond_done | byte_done;

    always_comb begin
        case (state)
            st_start:   nxt = st_ctrl_wr;
            st_ctrl_wr: nxt = st_addr_wr;
            st_addr_wr: nxt = op_rd ? st_restart : st_data_wr;
            st_data_wr: nxt = st_stop;
            st_restart: nxt = st_ctrl_rd;
            st_ctrl_rd: nxt = st_data_rd;
            st_data_rd: nxt = st_stop;
            st_stop:    nxt = st_done;
            default:    nxt = st_idle;
        endcase
    end

    // next phase is launched in the very cycle the previous one ends,
    // so no stray scl pulse lands between bytes and conditions
    assign launch_st = phase_end ? nxt : state;
    assign launch    = phase_end | (pending & bit_tick);

    always_comb begin
        cond_req  = 1'b0;
        cond_kind = cond_start;
        load      = 1'b0;
        load_byte = '0;
        dir       = dir_tx;
        case (launch_st)
            st_start, st_restart: begin
                cond_req = launch;
            end
            st_stop: begin
                cond_req  = launch;
                cond_kind = cond_stop;
            end
            st_ctrl_wr, st_ctrl_rd: begin
                load                   = launch;
                load_byte.ctrl.dev     = dev_code;
                load_byte.ctrl.blk     = addr[addr_w-1:data_w];
                load_byte.ctrl.rd_flag = (launch_st == st_ctrl_rd);
            end
            st_addr_wr: begin
                load          = launch;
                load_byte.raw = addr[data_w-1:0];
            end
            st_data_wr: begin
                load          = launch;
                load_byte.raw = wdata;
            end
            st_data_rd: begin
                load = launch;
                dir  = dir_rx;
            end
            default: ;
        endcase
    end

    assign master_ack_bit = 1'b1; // single byte read ends with no-acknowledge

    // master may drive sda only inside a byte phase
    assign bus_own = (state == st_ctrl_wr) || (state == st_addr_wr) ||
                     (state == st_data_wr) || (state == st_ctrl_rd) ||
                     (state == st_data_rd);

    assign ack = (state == st_done);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= st_idle;
            op_rd   <= 1'b0;
            pending <= 1'b0;
            nack    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (wr || rd) begin
                        state   <= st_start;
                        op_rd   <= ~wr;   // write wins
                        pending <= 1'b1;
                        nack    <= 1'b0;
                    end
                end
                st_done: state <= st_idle;
                default: begin
                    if (pending && bit_tick)
                        pending <= 1'b0;
                    if (phase_end)
                        state <= nxt;
                    // slave acks only, the read data slot carries our own bit
                    if (byte_done && state != st_data_rd && slave_ack)
                        nack <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (byte_done && state == st_data_rd)
            rdata <= rx_byte;
    end

endmodule

/* verilog/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int addr_w = 11;
    localparam int data_w = 8;

    localparam logic [3:0] dev_code_std = 4'b1010; // 24Cxx memory device code

    // shifter direction
    localparam logic dir_tx = 1'b0;
    localparam logic dir_rx = 1'b1;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_wr,
        st_addr_wr,
        st_data_wr,
        st_restart,
        st_ctrl_rd,
        st_data_rd,
        st_stop,
        st_done
    } ctrl_state_t;

    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] blk;     // address bits 10..8
        logic       rd_flag;
    } ctrl_byte_s;

    // one byte on the wire
    typedef union packed {
        ctrl_byte_s        ctrl;
        logic [data_w-1:0] raw;
    } ser_byte_u;

    typedef enum logic {
        cond_start,
        cond_stop
    } cond_kind_t;

endpackage

/* verilog/eeprom_rw.sv */
`timescale 1ns/1ns
module eeprom_rw import eeprom_pkg::*; #(
    parameter logic [3:0] dev_code = dev_code_std
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              ack,
    output logic              nack,
    output logic              scl,
    output logic              sda_out,
    output logic              sda_oe,
    input  logic              sda_in
);

    logic              bit_tick;
    logic              cond_req;
    cond_kind_t        cond_kind;
    logic              cond_done;
    logic              load;
    ser_byte_u         load_byte;
    logic              dir;
    logic              master_ack_bit;
    logic              bus_own;
    logic              tx_bit;
    logic              tx_active;
    logic              byte_done;
    logic              slave_ack;
    logic [data_w-1:0] rx_byte;

    eeprom_ctrl #(
        .dev_code(dev_code)
    ) u_ctrl (
        .CLK            (CLK),
        .RESET          (RESET),
        .wr             (wr),
        .rd             (rd),
        .addr           (addr),
        .wdata          (wdata),
        .bit_tick       (bit_tick),
        .cond_done      (cond_done),
        .byte_done      (byte_done),
        .slave_ack      (slave_ack),
        .rx_byte        (rx_byte),
        .cond_req       (cond_req),
        .cond_kind      (cond_kind),
        .load           (load),
        .load_byte      (load_byte),
        .dir            (dir),
        .master_ack_bit (master_ack_bit),
        .bus_own        (bus_own),
        .ack            (ack),
        .nack           (nack),
        .rdata          (rdata)
    );

    byte_shifter u_shifter (
        .CLK            (CLK),
        .RESET          (RESET),
        .bit_tick       (bit_tick),
        .load           (load),
        .load_byte      (load_byte),
        .dir            (dir),
        .master_ack_bit (master_ack_bit),
        .sda_in         (sda_in),
        .tx_bit         (tx_bit),
        .tx_active      (tx_active),
        .byte_done      (byte_done),
        .slave_ack      (slave_ack),
        .rx_byte        (rx_byte)
    );

    bus_condition u_cond (
        .CLK       (CLK),
        .RESET     (RESET),
        .cond_req  (cond_req),
        .cond_kind (cond_kind),
        .tx_bit    (tx_bit),
        .tx_active (tx_active),
        .bus_own   (bus_own),
        .scl       (scl),
        .bit_tick  (bit_tick),
        .cond_done (cond_done),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

endmodule
